// File: common/aluPkg.sv
package aluPkg;

  // encodings follow the execute-stage control field
  typedef enum logic [4:0] {
    opAdd    = 5'b00000,
    opSub    = 5'b00001,
    opAnd    = 5'b00010,
    opOr     = 5'b00011,
    opXor    = 5'b00100,
    opSlt    = 5'b00101,
    opFwdImm = 5'b00110,
    opSltu   = 5'b00111,
    opSll    = 5'b01000,
    opSrl    = 5'b01001,
    opSra    = 5'b01010,
    opMul    = 5'b01100, // low word
    opMulhu  = 5'b01101,
    opMulhsu = 5'b01110,
    opMulh   = 5'b01111,
    opBic    = 5'b10000, // arm only from here
    opAdc    = 5'b10010,
    opSbc    = 5'b10011,
    opRsb    = 5'b10100,
    opRsc    = 5'b10110,
    opMvn    = 5'b10111,
    opFwdOp1 = 5'b11111
  } aluOpE;

  typedef enum logic [1:0] {
    shLsl = 2'b00,
    shLsr = 2'b01,
    shAsr = 2'b10,
    shRor = 2'b11
  } shiftOpE;

  typedef enum logic [1:0] {
    mulUu = 2'b00,
    mulSs = 2'b01,
    mulSu = 2'b10 // a signed, b unsigned
  } mulSignE;

  typedef struct packed {
    logic neg;
    logic zero;
    logic carry;    // borrow after a subtract
    logic overflow;
  } flagsT;

endpackage

// File: common/pipePkg.sv
package pipePkg;

  typedef struct packed {
    logic            isArm;
    aluPkg::aluOpE   op;
    logic [31:0]     op1;
    logic [31:0]     op2;
    logic [2:0]      shiftType; // [1:0] arm shift kind, [2] amount from op1
    logic [4:0]      shiftAmt;
    aluPkg::flagsT   flagsIn;
  } execReqT;

  typedef struct packed {
    logic [1:0]       addMode;  // {invert a, invert b}
    logic             useCarry;
    aluPkg::shiftOpE  shiftOp;
    aluPkg::mulSignE  mulSign;
    aluPkg::aluOpE    op;
    logic             isArm;
  } ctrlT;

  typedef struct packed {
    ctrlT        ctrl;
    logic [31:0] op1;
    logic [31:0] op2;
    logic        shiftByReg;
    logic [4:0]  shiftAmt;
    logic        cIn;
  } decStageT;

  typedef struct packed {
    logic [31:0] result;
    logic        carry;
    logic        overflow;
  } exeStageT;

  typedef struct packed {
    logic [31:0]   result;
    aluPkg::flagsT flags;
  } execRspT;

endpackage

// File: alu/addSub.sv
module addSub (
  input  logic [31:0] a,
  input  logic [31:0] b,
  input  logic [1:0]  addMode,
  input  logic        useCarry,
  input  logic        cIn,
  output logic [31:0] q,
  output logic        cOut,
  output logic        overflow
);

  logic [31:0] aX;
  logic [31:0] bX;
  logic        isSub;
  logic        carryIn;
  logic        rawCarry;

  assign aX    = addMode[1] ? ~a : a;
  assign bX    = addMode[0] ? ~b : b;
  assign isSub = |addMode;

  // plain subtract adds one; with carry use the incoming borrow is taken off instead
  assign carryIn = isSub ^ (useCarry & cIn);

  assign {rawCarry, q} = aX + bX + {31'b0, carryIn};

  assign cOut     = rawCarry ^ isSub; // borrow for subtracts
  assign overflow = (aX[31] == bX[31]) && (q[31] != aX[31]);

endmodule

// File: alu/barrelShift.sv
module barrelShift (
  input  logic [31:0]     a,
  input  logic [4:0]      shift,
  input  aluPkg::shiftOpE op,
  output logic [31:0]     q
);
  import aluPkg::*;

  logic [31:0] lslLvl [0:5];
  logic [31:0] lsrLvl [0:5];
  logic [31:0] rorLvl [0:5];
  logic [31:0] fill;

  assign fill = {32{(op == shAsr) && a[31]}}; // sign fill only for asr

  // level i moves by 2**i when shift[i] is set
  always_comb begin
    lslLvl[0] = a;
    lsrLvl[0] = a;
    rorLvl[0] = a;
    for (int i = 0; i < 5; i++) begin
      if (shift[i]) begin
        lslLvl[i+1] = lslLvl[i] << (2 ** i);
        lsrLvl[i+1] = (lsrLvl[i] >> (2 ** i)) | (fill << (32 - 2 ** i));
        rorLvl[i+1] = (rorLvl[i] >> (2 ** i)) | (rorLvl[i] << (32 - 2 ** i));
      end else begin
        lslLvl[i+1] = lslLvl[i];
        lsrLvl[i+1] = lsrLvl[i];
        rorLvl[i+1] = rorLvl[i];
      end
    end
  end

  always_comb begin
    case (op)
      shLsl:   q = lslLvl[5];
      shRor:   q = rorLvl[5];
      default: q = lsrLvl[5]; // lsr and asr share the chain
    endcase
  end

endmodule

// File: alu/multiplier.sv
module multiplier (
  input  aluPkg::mulSignE sign,
  input  logic [31:0]     a,
  input  logic [31:0]     b,
  output logic [63:0]     q
);
  import aluPkg::*;

  logic signed [32:0] aExt;
  logic signed [32:0] bExt;
  logic signed [65:0] prod;

  // one extra bit per operand turns every form into a signed multiply
  assign aExt = {(sign != mulUu) && a[31], a};
  assign bExt = {(sign == mulSs) && b[31], b};

  assign prod = aExt * bExt;
  assign q    = prod[63:0];

endmodule

// File: alu/aluExec.sv
module aluExec (
  input  logic              clk,
  input  logic              rstN,
  input  logic              decValid,
  input  pipePkg::decStageT decData,
  output logic              hold,
  output logic              exeValid,
  output pipePkg::exeStageT exeData,
  input  logic              exeHold
);
  import aluPkg::*;
  import pipePkg::*;

  ctrlT        ctrl;
  logic [31:0] shiftIn;
  logic [4:0]  shiftAmount;
  logic [31:0] shiftResult;
  logic [31:0] op2Shifted;
  logic [31:0] addResult;
  logic        addCarry;
  logic        addOverflow;
  logic [63:0] mulResult;
  logic        isArith;
  logic [31:0] result;

  assign ctrl = decData.ctrl;
  assign hold = exeValid && exeHold;

  // risc-v shifts op1, arm shifts the second operand
  assign shiftIn = ctrl.isArm ? decData.op2 : decData.op1;

  always_comb begin
    if (!ctrl.isArm) begin
      shiftAmount = decData.op2[4:0];
    end else if (decData.shiftByReg) begin
      shiftAmount = decData.op1[4:0]; // register amount
    end else begin
      shiftAmount = decData.shiftAmt;
    end
  end

  barrelShift uShift (.a(shiftIn), .shift(shiftAmount), .op(ctrl.shiftOp), .q(shiftResult));

  assign op2Shifted = ctrl.isArm ? shiftResult : decData.op2;

  addSub uAddSub (
    .a(decData.op1), .b(op2Shifted), .addMode(ctrl.addMode), .useCarry(ctrl.useCarry),
    .cIn(decData.cIn), .q(addResult), .cOut(addCarry), .overflow(addOverflow)
  );

  multiplier uMul (.sign(ctrl.mulSign), .a(decData.op1), .b(decData.op2), .q(mulResult));

  assign isArith = ctrl.op inside {opAdd, opSub, opSlt, opSltu, opRsb, opAdc, opSbc, opRsc};

  always_comb begin
    case (ctrl.op)
      opAnd:    result = decData.op1 & op2Shifted;
      opOr:     result = decData.op1 | op2Shifted;
      opXor:    result = decData.op1 ^ op2Shifted;
      opFwdImm: result = op2Shifted;
      opSlt:    result = {31'b0, addResult[31] ^ addOverflow};
      opSltu:   result = {31'b0, addCarry}; // borrow means below
      opSll, opSrl, opSra: result = shiftResult;
      opMul:    result = mulResult[31:0];
      opMulh, opMulhsu, opMulhu: result = mulResult[63:32];
      opMvn:    result = ~op2Shifted;
      opBic:    result = decData.op1 & ~op2Shifted;
      opFwdOp1: result = decData.op1;
      default:  result = addResult; // add, sub, rsb, adc, sbc, rsc
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      exeValid <= 1'b0;
    end else if (!hold) begin
      exeValid <= decValid;
    end
  end

  always_ff @(posedge clk) begin
    if (decValid && !hold) begin
      exeData.result   <= result;
      exeData.carry    <= isArith ? addCarry : decData.cIn; // logic ops keep C
      exeData.overflow <= isArith && addOverflow;
    end
  end

  // stage 1 only forwards opcodes of the defined set
  assert property (@(posedge clk) disable iff (!rstN)
    decValid |-> ctrl.op inside {opAdd, opSub, opAnd, opOr, opXor, opSlt, opFwdImm,
      opSltu, opSll, opSrl, opSra, opMul, opMulh, opMulhsu, opMulhu, opBic, opAdc,
      opSbc, opRsb, opRsc, opMvn, opFwdOp1});

endmodule

// File: source/opDecode.sv
module opDecode (
  input  logic              clk,
  input  logic              rstN,
  input  logic              inReq,
  input  pipePkg::execReqT  inData,
  input  logic              hold,
  output logic              inAck,
  output logic              decValid,
  output pipePkg::decStageT decData
);
  import aluPkg::*;
  import pipePkg::*;

  typedef enum logic {sIdle, sAcked} inStateE;

  inStateE state;
  ctrlT    ctrlNext;
  logic    canLoad;
  logic    capture;

  assign canLoad = !(decValid && hold); // slot free or draining this edge
  assign capture = (state == sIdle) && inReq && canLoad;
  assign inAck   = (state == sAcked);

  always_comb begin
    ctrlNext.addMode  = {inData.op[4] & inData.op[2], inData.op[0]}; // rsb/rsc invert a
    ctrlNext.useCarry = inData.op[4] & inData.op[1]; // adc, sbc, rsc
    ctrlNext.shiftOp  = inData.isArm ? shiftOpE'(inData.shiftType[1:0])
                                     : shiftOpE'(inData.op[1:0]);
    case (inData.op)
      opMulh:   ctrlNext.mulSign = mulSs;
      opMulhsu: ctrlNext.mulSign = mulSu;
      default:  ctrlNext.mulSign = mulUu; // low word is sign independent
    endcase
    ctrlNext.op    = inData.op;
    ctrlNext.isArm = inData.isArm;
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state    <= sIdle;
      decValid <= 1'b0;
    end else begin
      if (capture) begin
        state <= sAcked;
      end else if (state == sAcked && !inReq) begin
        state <= sIdle; // producer released, drop ack
      end
      if (canLoad) begin
        decValid <= capture;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      decData.ctrl       <= ctrlNext;
      decData.op1        <= inData.op1;
      decData.op2        <= inData.op2;
      decData.shiftByReg <= inData.shiftType[2];
      decData.shiftAmt   <= inData.shiftAmt;
      decData.cIn        <= inData.flagsIn.carry;
    end
  end

endmodule

// File: source/resultStage.sv
module resultStage (
  input  logic              clk,
  input  logic              rstN,
  input  logic              exeValid,
  input  pipePkg::exeStageT exeData,
  input  logic              outAck,
  output logic              exeHold,
  output logic              outReq,
  output pipePkg::execRspT  outData
);
  import aluPkg::*;

  typedef enum logic [1:0] {sIdle, sReq, sAckWait} outStateE;

  outStateE state;
  flagsT    flagsNext;
  logic     load;

  assign exeHold = (state != sIdle); // busy until outAck falls
  assign load    = exeValid && (state == sIdle);
  assign outReq  = (state == sReq);

  always_comb begin
    flagsNext.neg      = exeData.result[31];
    flagsNext.zero     = (exeData.result == 32'b0);
    flagsNext.carry    = exeData.carry;
    flagsNext.overflow = exeData.overflow;
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= sIdle;
    end else begin
      case (state)
        sIdle:    if (load) state <= sReq;
        sReq:     if (outAck) state <= sAckWait;
        sAckWait: if (!outAck) state <= sIdle; // transfer done
        default:  state <= sIdle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      outData.result <= exeData.result;
      outData.flags  <= flagsNext;
    end
  end

  assert property (@(posedge clk) disable iff (!rstN) outReq |=> !outReq || $stable(outData));

endmodule

// File: source/execUnit.sv
module execUnit (
  input  logic             clk,
  input  logic             rstN,
  input  logic             inReq,
  input  pipePkg::execReqT inData,
  input  logic             outAck,
  output logic             inAck,
  output logic             outReq,
  output pipePkg::execRspT outData
);
  import pipePkg::*;

  logic     decValid;
  decStageT decData;
  logic     decHold;
  logic     exeValid;
  exeStageT exeData;
  logic     exeHold;

  opDecode uDecode (
    .clk(clk), .rstN(rstN), .inReq(inReq), .inData(inData), .hold(decHold),
    .inAck(inAck), .decValid(decValid), .decData(decData)
  );

  aluExec uExec (
    .clk(clk), .rstN(rstN), .decValid(decValid), .decData(decData), .hold(decHold),
    .exeValid(exeValid), .exeData(exeData), .exeHold(exeHold)
  );

  resultStage uResult (
    .clk(clk), .rstN(rstN), .exeValid(exeValid), .exeData(exeData), .outAck(outAck),
    .exeHold(exeHold), .outReq(outReq), .outData(outData)
  );

endmodule

// File: test/execUnitTb.sv
module execUnitTb;
  timeunit 1ns;
  timeprecision 100ps;

  import aluPkg::*;
  import pipePkg::*;

  // requests per test: 84 + 50 + 48 + 42 + 5
  localparam int numReqs    = 229;
  localparam int cycleLimit = 20 * (numReqs + 4);

  logic    clk;
  logic    rstN;
  logic    inReq;
  execReqT inData;
  logic    outAck;
  logic    inAck;
  logic    outReq;
  execRspT outData;

  execRspT     expQ [$];
  logic [31:0] edgeVals [3];
  int          cycles = 0;
  int          ackCycle;
  int          drainCycle;

  execUnit u_dut (
    .clk(clk), .rstN(rstN), .inReq(inReq), .inData(inData), .outAck(outAck),
    .inAck(inAck), .outReq(outReq), .outData(outData)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycleLimit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
      $display("Simulation failed");
      $fatal(1, "run stopped by timeout");
    end
  end

  function automatic logic [31:0] shiftModel(logic [31:0] x, logic [1:0] kind, logic [4:0] n);
    case (kind)
      2'd0:    return x << n;
      2'd1:    return x >> n;
      2'd2:    return $signed(x) >>> n;
      default: return (x >> n) | (x << (6'd32 - n)); // rotate right
    endcase
  endfunction

  function automatic void addModel(input logic [31:0] x, input logic [31:0] y, input logic c,
                                   output logic [31:0] s, output logic co, output logic v);
    logic [63:0] u;
    longint      sg;
    u  = {32'b0, x} + {32'b0, y} + {63'b0, c};
    sg = longint'($signed(x)) + longint'($signed(y)) + longint'(c);
    s  = u[31:0];
    co = u[32];
    v  = sg != longint'($signed(s)); // true sum out of 32-bit range
  endfunction

  // x - y - bIn with borrow out
  function automatic void subModel(input logic [31:0] x, input logic [31:0] y, input logic bIn,
                                   output logic [31:0] s, output logic bo, output logic v);
    logic [63:0] u;
    longint      sg;
    u  = {32'b0, x} - {32'b0, y} - {63'b0, bIn};
    sg = longint'($signed(x)) - longint'($signed(y)) - longint'(bIn);
    s  = u[31:0];
    bo = u[63];
    v  = sg != longint'($signed(s));
  endfunction

  function automatic execRspT expectedRsp(execReqT r);
    logic [31:0] b;
    logic [31:0] res;
    logic [63:0] p;
    logic        c;
    logic        v;
    execRspT     rsp;
    b = r.op2;
    if (r.isArm) begin
      b = shiftModel(r.op2, r.shiftType[1:0], r.shiftType[2] ? r.op1[4:0] : r.shiftAmt);
    end
    c = r.flagsIn.carry; // non-arith ops keep C
    v = 1'b0;
    case (r.op)
      opAdd:    addModel(r.op1, b, 1'b0, res, c, v);
      opAdc:    addModel(r.op1, b, r.flagsIn.carry, res, c, v);
      opSub:    subModel(r.op1, b, 1'b0, res, c, v);
      opSbc:    subModel(r.op1, b, r.flagsIn.carry, res, c, v);
      opRsb:    subModel(b, r.op1, 1'b0, res, c, v);
      opRsc:    subModel(b, r.op1, r.flagsIn.carry, res, c, v);
      opSlt: begin
        subModel(r.op1, b, 1'b0, res, c, v);
        res = {31'b0, $signed(r.op1) < $signed(b)};
      end
      opSltu: begin
        subModel(r.op1, b, 1'b0, res, c, v);
        res = {31'b0, r.op1 < b};
      end
      opAnd:    res = r.op1 & b;
      opOr:     res = r.op1 | b;
      opXor:    res = r.op1 ^ b;
      opFwdImm: res = b;
      opMvn:    res = ~b;
      opBic:    res = r.op1 & ~b;
      opFwdOp1: res = r.op1;
      opSll:    res = shiftModel(r.op1, 2'd0, r.op2[4:0]);
      opSrl:    res = shiftModel(r.op1, 2'd1, r.op2[4:0]);
      opSra:    res = shiftModel(r.op1, 2'd2, r.op2[4:0]);
      opMulh: begin
        p   = longint'($signed(r.op1)) * longint'($signed(r.op2));
        res = p[63:32];
      end
      opMulhsu: begin
        p   = longint'($signed(r.op1)) * longint'({32'b0, r.op2});
        res = p[63:32];
      end
      default: begin // mul and mulhu
        p   = {32'b0, r.op1} * {32'b0, r.op2};
        res = (r.op == opMul) ? p[31:0] : p[63:32];
      end
    endcase
    rsp.result         = res;
    rsp.flags.neg      = res[31];
    rsp.flags.zero     = (res == 32'b0);
    rsp.flags.carry    = c;
    rsp.flags.overflow = v;
    return rsp;
  endfunction

  function automatic execReqT makeReq(logic isArm, aluOpE op, logic [31:0] a, logic [31:0] b,
                                      logic [2:0] shiftType, logic [4:0] amt);
    execReqT r;
    r.isArm     = isArm;
    r.op        = op;
    r.op1       = a;
    r.op2       = b;
    r.shiftType = shiftType;
    r.shiftAmt  = amt;
    r.flagsIn   = flagsT'(4'($urandom()));
    return r;
  endfunction

  task automatic checkRsp(input execRspT exp, input execRspT act);
    if (act.result !== exp.result) begin
      $display("Error at %0d ns: outData.result expected %h, got %h",
               $time, exp.result, act.result);
      $display("Simulation failed");
      $fatal(1, "result mismatch");
    end
  endtask

  task automatic checkFlags(input flagsT exp, input flagsT act);
    if (act !== exp) begin
      $display("Error at %0d ns: outData.flags expected %b, got %b", $time, exp, act);
      $display("Simulation failed");
      $fatal(1, "flag mismatch");
    end
  endtask

  task automatic compareBit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Error at %0d ns: %s expected %b, got %b", $time, name, exp, act);
      $display("Simulation failed");
      $fatal(1, "handshake mismatch");
    end
  endtask

  // four-phase producer side
  task automatic sendReq(input execReqT r);
    expQ.push_back(expectedRsp(r));
    @(posedge clk);
    inReq  <= 1'b1;
    inData <= r;
    do @(posedge clk); while (!inAck);
    ackCycle = cycles;
    inReq <= 1'b0;
    do @(posedge clk); while (inAck);
  endtask

  task automatic recvRsp();
    execRspT got;
    execRspT exp;
    do @(posedge clk); while (!outReq);
    got = outData;
    exp = expQ.pop_front();
    checkRsp(exp, got);
    checkFlags(exp.flags, got.flags);
    outAck <= 1'b1;
    do @(posedge clk); while (outReq);
    outAck <= 1'b0;
    drainCycle = cycles;
  endtask

  task automatic runOne(input execReqT r);
    sendReq(r);
    recvRsp();
  endtask

  task automatic resetState();
    @(posedge clk);
    compareBit("inAck", 1'b0, inAck);
    compareBit("outReq", 1'b0, outReq);
  endtask

  // nine edge pairs, then three random pairs
  task automatic edgeSweep(input aluOpE op);
    logic [31:0] a;
    logic [31:0] b;
    for (int k = 0; k < 12; k++) begin
      a = (k < 9) ? edgeVals[k / 3] : $urandom();
      b = (k < 9) ? edgeVals[k % 3] : $urandom();
      runOne(makeReq(1'b0, op, a, b, 3'b000, 5'd0));
    end
  endtask

  task automatic arithLogic();
    aluOpE ops [7];
    ops = '{opAdd, opSub, opAnd, opOr, opXor, opSlt, opSltu};
    foreach (ops[i]) edgeSweep(ops[i]);
  endtask

  task automatic mulForms();
    aluOpE ops [4];
    ops = '{opMul, opMulh, opMulhsu, opMulhu};
    foreach (ops[i]) edgeSweep(ops[i]);
  endtask

  task automatic shiftKinds();
    aluOpE rvOps [3];
    rvOps = '{opSll, opSrl, opSra};
    foreach (rvOps[i]) begin
      for (int k = 0; k < 6; k++) begin
        runOne(makeReq(1'b0, rvOps[i], $urandom(), $urandom(), 3'b000, 5'd0));
      end
    end
    for (int kind = 0; kind < 4; kind++) begin
      for (int byReg = 0; byReg < 2; byReg++) begin
        for (int k = 0; k < 4; k++) begin
          runOne(makeReq(1'b1, k[0] ? opFwdImm : opAdd, $urandom(), $urandom(),
                         {byReg[0], kind[1:0]}, 5'($urandom())));
        end
      end
    end
  endtask

  task automatic armOps();
    aluOpE   ops [7];
    execReqT r;
    ops = '{opMvn, opBic, opRsb, opAdc, opSbc, opRsc, opFwdOp1};
    foreach (ops[i]) begin
      for (int c = 0; c < 2; c++) begin
        for (int k = 0; k < 3; k++) begin
          r = makeReq(1'b1, ops[i], $urandom(), $urandom(), {1'b0, 2'($urandom())},
                      5'($urandom()));
          r.flagsIn.carry = c[0];
          runOne(r);
        end
      end
    end
  endtask

  // consumer holds off so one item waits in each stage
  task automatic orderUnderStall();
    aluOpE ops [5];
    int    ackFourth;
    int    firstDrain;
    ops = '{opAdd, opSub, opXor, opMulh, opRsb};
    fork
      begin
        for (int i = 0; i < 5; i++) begin
          sendReq(makeReq(i == 4, ops[i], $urandom(), $urandom(), 3'b000, 5'd0));
          if (i == 3) ackFourth = ackCycle;
        end
      end
      begin
        repeat (30) @(posedge clk);
        recvRsp();
        firstDrain = drainCycle;
        repeat (4) recvRsp();
      end
    join
    if (ackFourth <= firstDrain) begin
      $display("Error: fourth request was acknowledged before the first result was taken");
      $display("Simulation failed");
      $fatal(1, "pipeline accepted too many items");
    end
  endtask

  initial begin
    void'($urandom(32'h3fe5));
    edgeVals = '{32'h0000_0000, 32'h8000_0000, 32'hffff_ffff};
    clk    = 1'b0;
    rstN   = 1'b0;
    inReq  = 1'b0;
    inData = '0;
    outAck = 1'b0;
    repeat (4) @(posedge clk);
    rstN <= 1'b1;
    resetState();
    arithLogic();
    shiftKinds();
    mulForms();
    armOps();
    orderUnderStall();
    repeat (8) @(posedge clk); // no extra result may follow
    if (outReq !== 1'b0) begin
      $display("Error at %0d ns: outReq expected 0, got %b", $time, outReq);
      $display("Simulation failed");
      $fatal(1, "unexpected result");
    end else begin
      $display("Simulation passed");
      $finish;
    end
  end

endmodule

// File: vlog.f
common/aluPkg.sv
common/pipePkg.sv
alu/addSub.sv
alu/barrelShift.sv
alu/multiplier.sv
alu/aluExec.sv
source/opDecode.sv
source/resultStage.sv
source/execUnit.sv
test/execUnitTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= execUnitTb
FILELIST  ?= vlog.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
PASS_TEXT ?= Simulation passed

SOURCES := $(shell cat $(FILELIST))
SIM     := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJDIR)
